//--- build.f
+incdir+design
design/v2p_pkg.sv
design/ctx_fifo.sv
design/dma_read_ctx.sv
design/rdctx_regs.sv
design/v2p_ctx_read_top.sv
dv/v2p_ctx_read_checker.sv
dv/v2p_ctx_read_tb.sv

//--- Bender.yml
package:
  name: v2p_ctx_read

sources:
  - include_dirs:
      - design
    files:
      - design/v2p_pkg.sv
      - design/ctx_fifo.sv
      - design/dma_read_ctx.sv
      - design/rdctx_regs.sv
      - design/v2p_ctx_read_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/v2p_ctx_read_checker.sv
      - dv/v2p_ctx_read_tb.sv

//--- dv/v2p_ctx_read_tb.sv
// v2p_ctx_read_tb
// drives the context-read front end, models the dma engine and mpt consumer
// expected heads and backups come from a reference mapping of each request
`include "v2p_config.svh"

module v2p_ctx_read_tb;

    logic                  clk;
    logic                  rst;
    logic                  mpt_req_wr_en;
    v2p_pkg::ctx_rd_req_t  mpt_req;
    logic                  mpt_req_full;
    logic                  mtt_req_wr_en;
    v2p_pkg::ctx_rd_req_t  mtt_req;
    logic                  mtt_req_full;
    logic                  mpt_bkup_rd_en;
    v2p_pkg::ctx_bkup_t    mpt_bkup;
    logic                  mpt_bkup_empty;
    logic                  mpt_rd_req_valid;
    v2p_pkg::dma_rd_head_t mpt_rd_req_head;
    logic                  mpt_rd_req_ready;
    logic                  mtt_rd_req_valid;
    v2p_pkg::dma_rd_head_t mtt_rd_req_head;
    logic                  mtt_rd_req_ready;
    logic                  cfg_wr_en;
    v2p_pkg::cfg_addr_t    cfg_addr;
    v2p_pkg::cfg_data_t    cfg_wdata;
    v2p_pkg::cfg_data_t    cfg_rdata;

    // expected traffic with the oldest entry first
    v2p_pkg::dma_rd_head_t exp_mpt[$];
    v2p_pkg::dma_rd_head_t exp_mtt[$];
    v2p_pkg::ctx_bkup_t    exp_bkup[$];

    logic [31:0] lfsr_state = 32'h08ea_351d;
    int          mpt_seen = 0;
    int          mtt_seen = 0;
    int          val_errors = 0;
    int          other_errors = 0;
    string       test_name = "reset";
    int          base;
    int          base_mpt;
    int          n;
    int          i;
    v2p_pkg::cfg_data_t rd;

    v2p_ctx_read_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    // stepped once per bit
    function automatic logic [63:0] rand_bits(input int nbits);
        logic [63:0] r;
        logic        fb;
        int          k;
        r = '0;
        for (k = 0; k < nbits; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic v2p_pkg::ctx_rd_req_t rand_req();
        v2p_pkg::ctx_rd_req_t r;
        r.index  = rand_bits(64);
        r.opcode = v2p_pkg::ctx_opcode_t'(rand_bits(3));
        r.len    = v2p_pkg::ctx_len_t'(rand_bits(32));
        r.addr   = rand_bits(64);
        return r;
    endfunction

    // reference mapping of a request
    // head keeps addr and low 12 bits of len
    // backup keeps index, opcode and len
    function automatic v2p_pkg::dma_rd_head_t ref_map(input v2p_pkg::ctx_rd_req_t req,
                                                      output v2p_pkg::ctx_bkup_t bk);
        bk = {req.index, req.opcode, req.len};
        return {32'h0, req.addr, 20'h0, req.len[11:0]};
    endfunction

    task automatic check_val(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
        assert (act === exp) else begin
            val_errors++;
            $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    // ------------------------------------------------------------
    // bus helpers start and end 1 unit after a rising edge
    // ------------------------------------------------------------
    task automatic push_req(input bit is_mpt, input v2p_pkg::ctx_rd_req_t req);
        v2p_pkg::ctx_bkup_t    bk;
        v2p_pkg::dma_rd_head_t hd;
        hd = ref_map(req, bk);
        if (is_mpt) begin
            mpt_req       = req;
            mpt_req_wr_en = 1'b1;
            exp_mpt.push_back(hd);
            exp_bkup.push_back(bk);
        end else begin
            mtt_req       = req;
            mtt_req_wr_en = 1'b1;
            exp_mtt.push_back(hd);
        end
        @(posedge clk);
        #1;
        mpt_req_wr_en = 1'b0;
        mtt_req_wr_en = 1'b0;
    endtask

    // mpt consumer pops one entry
    task automatic pop_backup();
        int k;
        k = 0;
        while (mpt_bkup_empty && k < 100) begin
            @(posedge clk);
            #1;
            k++;
        end
        assert (!mpt_bkup_empty) else begin
            other_errors++;
            $display("%s: timed out waiting for a backup entry", test_name);
        end
        if (!mpt_bkup_empty) begin
            mpt_bkup_rd_en = 1'b1;
            @(posedge clk);
            #1;
            mpt_bkup_rd_en = 1'b0;
        end
    endtask

    task automatic wait_issued(input bit is_mpt, input int target);
        int k;
        k = 0;
        while ((is_mpt ? mpt_seen : mtt_seen) < target && k < 200) begin
            @(posedge clk);
            #1;
            k++;
        end
        assert ((is_mpt ? mpt_seen : mtt_seen) >= target) else begin
            other_errors++;
            $display("%s: timed out waiting for %0d issued requests", test_name, target);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input v2p_pkg::cfg_addr_t a, input v2p_pkg::cfg_data_t d);
        cfg_wr_en = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(posedge clk);
        #1;
        cfg_wr_en = 1'b0;
    endtask

    // rdata is combinational so it is sampled mid-cycle
    task automatic read_reg(input v2p_pkg::cfg_addr_t a, output v2p_pkg::cfg_data_t d);
        cfg_addr = a;
        @(negedge clk);
        d = cfg_rdata;
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------
    // comparison on the falling edge where outputs are settled
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            if (mpt_rd_req_valid) begin
                mpt_seen++;
                assert (exp_mpt.size() > 0) else begin
                    other_errors++;
                    $display("%s: mpt valid with no request outstanding", test_name);
                end
                if (exp_mpt.size() > 0) begin
                    check_val("mpt head", exp_mpt.pop_front(), mpt_rd_req_head);
                end
            end
            if (mtt_rd_req_valid) begin
                mtt_seen++;
                assert (exp_mtt.size() > 0) else begin
                    other_errors++;
                    $display("%s: mtt valid with no request outstanding", test_name);
                end
                if (exp_mtt.size() > 0) begin
                    check_val("mtt head", exp_mtt.pop_front(), mtt_rd_req_head);
                end
            end
            // backup pop this cycle
            if (mpt_bkup_rd_en && !mpt_bkup_empty) begin
                assert (exp_bkup.size() > 0) else begin
                    other_errors++;
                    $display("%s: backup popped with none expected", test_name);
                end
                if (exp_bkup.size() > 0) begin
                    check_val("backup", exp_bkup.pop_front(), mpt_bkup);
                end
            end
        end
    end

    initial begin
        rst              = 1'b1;
        mpt_req_wr_en    = 1'b0;
        mpt_req          = '0;
        mtt_req_wr_en    = 1'b0;
        mtt_req          = '0;
        mpt_bkup_rd_en   = 1'b0;
        mpt_rd_req_ready = 1'b1;
        mtt_rd_req_ready = 1'b1;
        cfg_wr_en        = 1'b0;
        cfg_addr         = '0;
        cfg_wdata        = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        read_reg(`V2P_REG_CTRL, rd);
        check_val("ctrl after reset", 3, rd);
        check_val("backup empty after reset", 1, mpt_bkup_empty);

        // single mpt gives valid two cycles after the push
        test_name = "single_mpt";
        push_req(1'b1, rand_req());
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!mpt_rd_req_valid && n < 10);
        check_val("valid latency", 2, n);
        @(posedge clk);
        #1;
        pop_backup();

        test_name = "mtt_burst";
        base = mtt_seen;
        for (i = 0; i < 10; i++) push_req(1'b0, rand_req());
        wait_issued(1'b0, base + 10);
        check_val("no backup from mtt", 1, mpt_bkup_empty);

        // dma engine stalls mtt for a random stretch
        test_name = "mtt_backpressure";
        base = mtt_seen;
        mtt_rd_req_ready = 1'b0;
        for (i = 0; i < `V2P_REQ_FIFO_DEPTH; i++) push_req(1'b0, rand_req());
        check_val("mtt queue full", 1, mtt_req_full);
        idle(8 + int'(rand_bits(4)));
        check_val("issued while not ready", base, mtt_seen);
        mtt_rd_req_ready = 1'b1;
        wait_issued(1'b0, base + `V2P_REQ_FIFO_DEPTH);

        // fill backups to the threshold one at a time, then fill the request queue
        test_name = "bkup_threshold";
        base = mpt_seen;
        for (i = 0; i < `V2P_BKUP_PROG_FULL; i++) begin
            push_req(1'b1, rand_req());
            wait_issued(1'b1, base + i + 1);
        end
        for (i = 0; i < `V2P_REQ_FIFO_DEPTH; i++) push_req(1'b1, rand_req());
        check_val("mpt queue full", 1, mpt_req_full);
        idle(20);
        check_val("mpt issued at threshold", base + `V2P_BKUP_PROG_FULL, mpt_seen);
        read_reg(`V2P_REG_BKUP_LVL, rd);
        check_val("backup level", `V2P_BKUP_PROG_FULL, rd);
        for (i = 0; i < `V2P_BKUP_PROG_FULL + `V2P_REQ_FIFO_DEPTH; i++) pop_backup();
        check_val("mpt issued after drain",
                  base + `V2P_BKUP_PROG_FULL + `V2P_REQ_FIFO_DEPTH, mpt_seen);

        // mtt disabled while mpt keeps going and counters track valids
        test_name = "ctrl_disable";
        write_reg(`V2P_REG_MPT_CNT, '0);
        write_reg(`V2P_REG_MTT_CNT, '0);
        base_mpt = mpt_seen;
        base = mtt_seen;
        write_reg(`V2P_REG_CTRL, 32'd1);
        for (i = 0; i < 4; i++) begin
            push_req(1'b1, rand_req());
            push_req(1'b0, rand_req());
        end
        wait_issued(1'b1, base_mpt + 4);
        idle(10);
        check_val("mtt issued while disabled", base, mtt_seen);
        read_reg(`V2P_REG_MPT_CNT, rd);
        check_val("mpt counter", mpt_seen - base_mpt, rd);
        read_reg(`V2P_REG_MTT_CNT, rd);
        check_val("mtt counter", mtt_seen - base, rd);
        for (i = 0; i < 4; i++) pop_backup();
        write_reg(`V2P_REG_CTRL, 32'd3);
        wait_issued(1'b0, base + 4);
        read_reg(`V2P_REG_MTT_CNT, rd);
        check_val("mtt counter enabled", mtt_seen - base, rd);
        write_reg(`V2P_REG_MTT_CNT, 32'hffff_ffff);
        read_reg(`V2P_REG_MTT_CNT, rd);
        check_val("mtt counter cleared", 0, rd);

        check_val("outstanding expected", 0, exp_mpt.size() + exp_mtt.size() + exp_bkup.size());
        assert (i_dut.u_rd_ctx.u_checker.fail_count == 0) else begin
            other_errors++;
            $display("issuer assertions failed %0d times",
                     i_dut.u_rd_ctx.u_checker.fail_count);
        end
        $display("errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
        if (val_errors + other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- dv/v2p_ctx_read_checker.sv
// v2p_ctx_read_checker
// pop, push and pulse rules of the request issuer, bound into dma_read_ctx
module v2p_ctx_read_checker (
    input logic clk,
    input logic rst,
    input logic mpt_req_rd_en,
    input logic mtt_req_rd_en,
    input logic mpt_rd_req_ready,
    input logic mtt_rd_req_ready,
    input logic bkup_prog_full,
    input logic bkup_wr_en,
    input logic mpt_rd_req_valid,
    input logic mtt_rd_req_valid
);

    // number of failed assertions
    int fail_count = 0;

    // no pop while the dma engine is not ready
    mpt_pop_ready: assert property (@(posedge clk) disable iff (rst)
        mpt_req_rd_en |-> mpt_rd_req_ready)
        else begin
            $error("mpt pop with ready low");
            fail_count++;
        end
    mtt_pop_ready: assert property (@(posedge clk) disable iff (rst)
        mtt_req_rd_en |-> mtt_rd_req_ready)
        else begin
            $error("mtt pop with ready low");
            fail_count++;
        end

    // backup queue above threshold blocks mpt
    mpt_pop_room: assert property (@(posedge clk) disable iff (rst)
        mpt_req_rd_en |-> !bkup_prog_full)
        else begin
            $error("mpt pop with backup prog_full");
            fail_count++;
        end

    // one cycle from pop to valid, mpt also writes its backup
    mpt_pulse: assert property (@(posedge clk) disable iff (rst)
        mpt_req_rd_en |=> mpt_rd_req_valid && bkup_wr_en)
        else begin
            $error("mpt pop without pulse");
            fail_count++;
        end
    mtt_pulse: assert property (@(posedge clk) disable iff (rst)
        mtt_req_rd_en |=> mtt_rd_req_valid)
        else begin
            $error("mtt pop without valid");
            fail_count++;
        end

endmodule

bind dma_read_ctx v2p_ctx_read_checker u_checker (.*);

//--- design/v2p_ctx_read_top.sv
// v2p_ctx_read_top
// context-read front end: request queues, backup queue, issuer, registers
`include "v2p_config.svh"

module v2p_ctx_read_top (
    input  logic                  clk,
    input  logic                  rst,
    // request pushes from metadata logic
    input  logic                  mpt_req_wr_en,
    input  v2p_pkg::ctx_rd_req_t  mpt_req,
    output logic                  mpt_req_full,
    input  logic                  mtt_req_wr_en,
    input  v2p_pkg::ctx_rd_req_t  mtt_req,
    output logic                  mtt_req_full,
    // backup pop from mpt consumer
    input  logic                  mpt_bkup_rd_en,
    output v2p_pkg::ctx_bkup_t    mpt_bkup,
    output logic                  mpt_bkup_empty,
    // dma engine
    output logic                  mpt_rd_req_valid,
    output v2p_pkg::dma_rd_head_t mpt_rd_req_head,
    input  logic                  mpt_rd_req_ready,
    output logic                  mtt_rd_req_valid,
    output v2p_pkg::dma_rd_head_t mtt_rd_req_head,
    input  logic                  mtt_rd_req_ready,
    // register port
    input  logic                  cfg_wr_en,
    input  v2p_pkg::cfg_addr_t    cfg_addr,
    input  v2p_pkg::cfg_data_t    cfg_wdata,
    output v2p_pkg::cfg_data_t    cfg_rdata
);

    localparam int REQ_W  = $bits(v2p_pkg::ctx_rd_req_t);
    localparam int BKUP_W = $bits(v2p_pkg::ctx_bkup_t);

    v2p_pkg::ctx_rd_req_t                       mpt_req_dout;
    v2p_pkg::ctx_rd_req_t                       mtt_req_dout;
    logic                                       mpt_req_empty;
    logic                                       mtt_req_empty;
    logic                                       mpt_req_rd_en;
    logic                                       mtt_req_rd_en;
    logic                                       bkup_wr_en;
    v2p_pkg::ctx_bkup_t                         bkup_din;
    logic                                       bkup_prog_full;
    logic [$clog2(`V2P_BKUP_FIFO_DEPTH+1)-1:0]  bkup_level;
    logic                                       mpt_en;
    logic                                       mtt_en;

    // ----------------------------------------------------------
    // queues
    // ----------------------------------------------------------
    ctx_fifo #(
        .WIDTH(REQ_W), .DEPTH(`V2P_REQ_FIFO_DEPTH), .PROG_FULL(`V2P_REQ_FIFO_DEPTH)
    ) u_mpt_req_fifo (
        .clk(clk), .rst(rst),
        .wr_en(mpt_req_wr_en), .din(mpt_req),
        .rd_en(mpt_req_rd_en), .dout(mpt_req_dout),
        .full(mpt_req_full), .empty(mpt_req_empty),
        .prog_full(), .level()
    );

    ctx_fifo #(
        .WIDTH(REQ_W), .DEPTH(`V2P_REQ_FIFO_DEPTH), .PROG_FULL(`V2P_REQ_FIFO_DEPTH)
    ) u_mtt_req_fifo (
        .clk(clk), .rst(rst),
        .wr_en(mtt_req_wr_en), .din(mtt_req),
        .rd_en(mtt_req_rd_en), .dout(mtt_req_dout),
        .full(mtt_req_full), .empty(mtt_req_empty),
        .prog_full(), .level()
    );

    // threshold leaves headroom for backups still in flight
    ctx_fifo #(
        .WIDTH(BKUP_W), .DEPTH(`V2P_BKUP_FIFO_DEPTH), .PROG_FULL(`V2P_BKUP_PROG_FULL)
    ) u_bkup_fifo (
        .clk(clk), .rst(rst),
        .wr_en(bkup_wr_en), .din(bkup_din),
        .rd_en(mpt_bkup_rd_en), .dout(mpt_bkup),
        .full(), .empty(mpt_bkup_empty),
        .prog_full(bkup_prog_full), .level(bkup_level)
    );

    // ----------------------------------------------------------
    // issuer and registers
    // ----------------------------------------------------------
    dma_read_ctx u_rd_ctx (
        .clk(clk), .rst(rst),
        .mpt_req(mpt_req_dout), .mpt_req_empty(mpt_req_empty), .mpt_req_rd_en(mpt_req_rd_en),
        .mtt_req(mtt_req_dout), .mtt_req_empty(mtt_req_empty), .mtt_req_rd_en(mtt_req_rd_en),
        .bkup_prog_full(bkup_prog_full), .bkup_wr_en(bkup_wr_en), .bkup_din(bkup_din),
        .mpt_en(mpt_en), .mtt_en(mtt_en),
        .mpt_rd_req_valid(mpt_rd_req_valid), .mpt_rd_req_head(mpt_rd_req_head),
        .mpt_rd_req_ready(mpt_rd_req_ready),
        .mtt_rd_req_valid(mtt_rd_req_valid), .mtt_rd_req_head(mtt_rd_req_head),
        .mtt_rd_req_ready(mtt_rd_req_ready)
    );

    // valid pulses count as issues
    rdctx_regs u_regs (
        .clk(clk), .rst(rst),
        .cfg_wr_en(cfg_wr_en), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
        .mpt_issue(mpt_rd_req_valid), .mtt_issue(mtt_rd_req_valid),
        .bkup_level(bkup_level),
        .mpt_en(mpt_en), .mtt_en(mtt_en)
    );

endmodule

//--- design/rdctx_regs.sv
// rdctx_regs
// channel enable control, per-channel issue counters, backup level status
// writes land on the next edge, reads are combinational
`include "v2p_config.svh"

module rdctx_regs (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      cfg_wr_en,
    input  v2p_pkg::cfg_addr_t                        cfg_addr,
    input  v2p_pkg::cfg_data_t                        cfg_wdata,
    output v2p_pkg::cfg_data_t                        cfg_rdata,
    input  logic                                      mpt_issue,
    input  logic                                      mtt_issue,
    input  logic [$clog2(`V2P_BKUP_FIFO_DEPTH+1)-1:0] bkup_level,
    output logic                                      mpt_en,
    output logic                                      mtt_en
);

    // bit 0 enables mpt, bit 1 enables mtt
    logic [1:0]         ctrl_q;
    v2p_pkg::cfg_data_t mpt_cnt_q;
    v2p_pkg::cfg_data_t mtt_cnt_q;

    // ----------------------------------------------------------
    // write side
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_q    <= 2'b11;
            mpt_cnt_q <= '0;
            mtt_cnt_q <= '0;
        end else begin
            if (cfg_wr_en && cfg_addr == `V2P_REG_CTRL) begin
                ctrl_q <= cfg_wdata[1:0];
            end
            // any write to a counter clears it, wraps otherwise
            if (cfg_wr_en && cfg_addr == `V2P_REG_MPT_CNT) begin
                mpt_cnt_q <= '0;
            end else if (mpt_issue) begin
                mpt_cnt_q <= mpt_cnt_q + 1'b1;
            end
            if (cfg_wr_en && cfg_addr == `V2P_REG_MTT_CNT) begin
                mtt_cnt_q <= '0;
            end else if (mtt_issue) begin
                mtt_cnt_q <= mtt_cnt_q + 1'b1;
            end
        end
    end

    // read mux
    always_comb begin
        case (cfg_addr)
            `V2P_REG_CTRL:    cfg_rdata = {30'b0, ctrl_q};
            `V2P_REG_MPT_CNT: cfg_rdata = mpt_cnt_q;
            `V2P_REG_MTT_CNT: cfg_rdata = mtt_cnt_q;
            default:          cfg_rdata = v2p_pkg::cfg_data_t'(bkup_level);
        endcase
    end

    assign mpt_en = ctrl_q[0];
    assign mtt_en = ctrl_q[1];

endmodule

//--- design/dma_read_ctx.sv
// dma_read_ctx
// pops mpt/mtt context requests and turns each into a one-beat dma read head
// mpt requests also leave a backup entry for the mpt consumer
module dma_read_ctx (
    input  logic                   clk,
    input  logic                   rst,
    // mpt request queue
    input  v2p_pkg::ctx_rd_req_t   mpt_req,
    input  logic                   mpt_req_empty,
    output logic                   mpt_req_rd_en,
    // mtt request queue
    input  v2p_pkg::ctx_rd_req_t   mtt_req,
    input  logic                   mtt_req_empty,
    output logic                   mtt_req_rd_en,
    // backup queue write side
    input  logic                   bkup_prog_full,
    output logic                   bkup_wr_en,
    output v2p_pkg::ctx_bkup_t     bkup_din,
    // channel enables
    input  logic                   mpt_en,
    input  logic                   mtt_en,
    // dma engine
    output logic                   mpt_rd_req_valid,
    output v2p_pkg::dma_rd_head_t  mpt_rd_req_head,
    input  logic                   mpt_rd_req_ready,
    output logic                   mtt_rd_req_valid,
    output v2p_pkg::dma_rd_head_t  mtt_rd_req_head,
    input  logic                   mtt_rd_req_ready
);

    logic                  mpt_pop;
    logic                  mtt_pop;
    logic                  mpt_valid_q;
    logic                  mtt_valid_q;
    logic                  bkup_wr_q;
    v2p_pkg::dma_rd_head_t mpt_head_q;
    v2p_pkg::dma_rd_head_t mtt_head_q;
    v2p_pkg::ctx_bkup_t    bkup_din_q;

    // addr passes through, byte length keeps the low 12 bits of len
    function automatic v2p_pkg::dma_rd_head_t make_head(input v2p_pkg::ctx_rd_req_t req);
        v2p_pkg::dma_rd_head_t head;
        head          = '0;
        head.addr     = req.addr;
        head.byte_len = req.len[11:0];
        return head;
    endfunction

    // ----------------------------------------------------------
    // pop decision
    // ----------------------------------------------------------
    // mpt also needs the backup queue below its threshold
    assign mpt_pop = !mpt_req_empty && mpt_rd_req_ready && !bkup_prog_full && mpt_en;
    assign mtt_pop = !mtt_req_empty && mtt_rd_req_ready && mtt_en;

    assign mpt_req_rd_en = mpt_pop;
    assign mtt_req_rd_en = mtt_pop;

    // ----------------------------------------------------------
    // registered strobes one cycle after the pop
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mpt_valid_q <= 1'b0;
            mtt_valid_q <= 1'b0;
            bkup_wr_q   <= 1'b0;
        end else begin
            mpt_valid_q <= mpt_pop;
            bkup_wr_q   <= mpt_pop;
            mtt_valid_q <= mtt_pop;
        end
    end

    // head and backup payload are zero whenever nothing was popped
    always_ff @(posedge clk) begin
        mpt_head_q <= mpt_pop ? make_head(mpt_req) : '0;
        mtt_head_q <= mtt_pop ? make_head(mtt_req) : '0;
        if (mpt_pop) begin
            bkup_din_q.index  <= mpt_req.index;
            bkup_din_q.opcode <= mpt_req.opcode;
            bkup_din_q.len    <= mpt_req.len;
        end else begin
            bkup_din_q <= '0;
        end
    end

    assign mpt_rd_req_valid = mpt_valid_q;
    assign mpt_rd_req_head  = mpt_head_q;
    assign mtt_rd_req_valid = mtt_valid_q;
    assign mtt_rd_req_head  = mtt_head_q;
    assign bkup_wr_en       = bkup_wr_q;
    assign bkup_din         = bkup_din_q;

endmodule

//--- design/ctx_fifo.sv
// ctx_fifo
// first-word-fall-through synchronous fifo, head entry visible on dout
// occupancy count and programmable-full flag
module ctx_fifo #(
    parameter int WIDTH     = 8,
    parameter int DEPTH     = 16,
    parameter int PROG_FULL = 12
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_en,
    input  logic [WIDTH-1:0]           din,
    input  logic                       rd_en,
    output logic [WIDTH-1:0]           dout,
    output logic                       full,
    output logic                       empty,
    output logic                       prog_full,
    output logic [$clog2(DEPTH+1)-1:0] level
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // wrap at DEPTH-1, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // overflow and underflow attempts are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // occupancy only moves on a one-sided access
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage array
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    assign dout      = mem[rd_ptr];
    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= CNT_W'(PROG_FULL));
    assign level     = count;

endmodule

//--- design/v2p_pkg.sv
// v2p context-read types
// request, backup and dma read head layouts plus width typedefs
package v2p_pkg;

    // ----------------------------------------------------------
    // field widths
    // ----------------------------------------------------------
    typedef logic [63:0] ctx_index_t;
    typedef logic [2:0]  ctx_opcode_t;
    typedef logic [31:0] ctx_len_t;
    typedef logic [63:0] host_addr_t;
    typedef logic [11:0] dma_len_t;

    // register port
    typedef logic [1:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;

    // ----------------------------------------------------------
    // queue entries
    // ----------------------------------------------------------
    // request from metadata logic, 163 bits, index at the top
    typedef struct packed {
        ctx_index_t  index;
        ctx_opcode_t opcode;
        ctx_len_t    len;
        host_addr_t  addr;
    } ctx_rd_req_t;

    // mpt backup, 99 bits, matched against returning data
    typedef struct packed {
        ctx_index_t  index;
        ctx_opcode_t opcode;
        ctx_len_t    len;
    } ctx_bkup_t;

    // single-beat dma read head, 128 bits
    // reserved fields stay zero
    typedef struct packed {
        logic [31:0] rsvd_hi;
        host_addr_t  addr;
        logic [19:0] rsvd_lo;
        dma_len_t    byte_len;
    } dma_rd_head_t;

endpackage

//--- design/v2p_config.svh
// v2p context-read front end configuration
// queue depths, backup threshold and register map
`ifndef V2P_CONFIG_SVH
`define V2P_CONFIG_SVH

// ----------------------------------------------------------
// queue sizing
// ----------------------------------------------------------
`define V2P_REQ_FIFO_DEPTH  16
`define V2P_BKUP_FIFO_DEPTH 32
// backup occupancy at which mpt issue holds off
`define V2P_BKUP_PROG_FULL  24

// ----------------------------------------------------------
// register map
// ----------------------------------------------------------
`define V2P_REG_CTRL     2'd0
`define V2P_REG_MPT_CNT  2'd1
`define V2P_REG_MTT_CNT  2'd2
`define V2P_REG_BKUP_LVL 2'd3

`endif
